//--- rtl/axis_demux.sv
`timescale 1ns/10ps
`default_nettype none
// ****************************************
// AXI4-Stream packet router with drop counter
// ****************************************

module axis_demux (
    input  logic                                    aclk,
    input  logic                                    reset,
    // single input stream
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  axis_pkg::axis_beat_t                    in_beat,
    // one stream per output
    output logic [axis_pkg::OUTPUTS-1:0]            out_valid,
    input  logic [axis_pkg::OUTPUTS-1:0]            out_ready,
    output axis_pkg::axis_beat_t                    out_beat [axis_pkg::OUTPUTS],
    output logic [axis_pkg::DROP_COUNT_WIDTH-1:0]   drop_count
);

    logic                                in_packet;
    logic [axis_pkg::DEST_BITS-1:0]      sel_q;
    logic                                drop_q;
    logic [axis_pkg::DEST_BITS-1:0]      field;
    logic [axis_pkg::DEST_BITS-1:0]      cur_port;
    logic                                cur_drop;
    logic [axis_pkg::OUTPUTS-1:0]        route;
    logic                                in_xfer;

    // routing field of the beat currently offered.
    assign field = in_beat.tdest[axis_pkg::DEST_OFFSET +: axis_pkg::DEST_BITS];

    // a first beat decides from its own tdest, later beats follow the lock.
    assign cur_port = in_packet ? sel_q : field;
    assign cur_drop = in_packet ? drop_q
                                : (32'(field) >= axis_pkg::OUTPUTS);

    // one-hot select of the target stream, empty while dropping.
    always_comb begin
        for (int k = 0; k < axis_pkg::OUTPUTS; k++) begin
            route[k] = !cur_drop && (cur_port == axis_pkg::DEST_BITS'(k));
        end
    end

    assign out_valid = route & {axis_pkg::OUTPUTS{in_valid}};

    // a dropped packet is swallowed at full rate.
    assign in_ready  = cur_drop || |(route & out_ready);
    assign in_xfer   = in_valid && in_ready;

    // the payload fans out to every stream; only out_valid selects.
    generate
        for (genvar k = 0; k < axis_pkg::OUTPUTS; k++) begin : g_fanout
            assign out_beat[k] = in_beat;
        end
    endgenerate

    // packet lock state, cleared by the tlast beat.
    always_ff @(posedge aclk) begin
        if (reset) begin
            in_packet <= 1'b0;
            sel_q     <= '0;
            drop_q    <= 1'b0;
        end else if (in_xfer) begin
            if (in_beat.tlast) begin
                in_packet <= 1'b0;
            end else begin
                in_packet <= 1'b1;
                sel_q     <= cur_port;
                drop_q    <= cur_drop;
            end
        end
    end

    // Count a dropped packet once, on its tlast beat.
    always_ff @(posedge aclk) begin
        if (reset) begin
            drop_count <= '0;
        end else if (in_xfer && in_beat.tlast && cur_drop) begin
            drop_count <= drop_count + 1'b1;
        end
    end

    assert property (@(posedge aclk) disable iff (reset)
        $onehot0(out_valid))
    else $error("router drives more than one output valid");

    // once a non-final beat is taken, the next beat goes to the same place.
    assert property (@(posedge aclk) disable iff (reset)
        in_xfer && !in_beat.tlast |=>
            cur_port == $past(cur_port) && cur_drop == $past(cur_drop))
    else $error("router changed its target in the middle of a packet");

endmodule

`default_nettype wire

//--- rtl/axis_demux_top.sv
`timescale 1ns/10ps
`default_nettype none
// ****************************************
// AXI4-Stream demux top level with flat ports
// input slice, router and one slice per output
// ****************************************

module axis_demux_top (
    input  logic                                                       aclk,
    input  logic                                                       reset,
    // rx
    input  logic                                                       rx_tvalid,
    output logic                                                       rx_tready,
    input  logic                                                       rx_tlast,
    input  logic [axis_pkg::TDATA_BYTES-1:0][7:0]                      rx_tdata,
    input  logic [axis_pkg::TDATA_BYTES-1:0]                           rx_tstrb,
    input  logic [axis_pkg::TDATA_BYTES-1:0]                           rx_tkeep,
    input  logic [axis_pkg::TDEST_WIDTH-1:0]                           rx_tdest,
    input  logic [axis_pkg::TUSER_WIDTH-1:0]                           rx_tuser,
    // tx
    output logic [axis_pkg::OUTPUTS-1:0]                               tx_tvalid,
    input  logic [axis_pkg::OUTPUTS-1:0]                               tx_tready,
    output logic [axis_pkg::OUTPUTS-1:0]                               tx_tlast,
    output logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0][7:0] tx_tdata,
    output logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0]    tx_tstrb,
    output logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0]    tx_tkeep,
    output logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDEST_WIDTH-1:0]    tx_tdest,
    output logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TUSER_WIDTH-1:0]    tx_tuser,
    // status
    output logic [axis_pkg::DROP_COUNT_WIDTH-1:0]                      drop_count
);

    axis_pkg::axis_beat_t                rx_beat;
    logic                                mid_valid;
    logic                                mid_ready;
    axis_pkg::axis_beat_t                mid_beat;
    logic [axis_pkg::OUTPUTS-1:0]        route_valid;
    logic [axis_pkg::OUTPUTS-1:0]        route_ready;
    axis_pkg::axis_beat_t                route_beat [axis_pkg::OUTPUTS];
    axis_pkg::axis_beat_t                tx_beat    [axis_pkg::OUTPUTS];

    always_comb begin
        rx_beat.tlast = rx_tlast;
        rx_beat.tdata = rx_tdata;
        rx_beat.tstrb = rx_tstrb;
        rx_beat.tkeep = rx_tkeep;
        rx_beat.tdest = rx_tdest;
        rx_beat.tuser = rx_tuser;
    end

    axis_skid_buffer rx_slice_i (
        .aclk      (aclk),
        .reset     (reset),
        .in_valid  (rx_tvalid),
        .in_ready  (rx_tready),
        .in_beat   (rx_beat),
        .out_valid (mid_valid),
        .out_ready (mid_ready),
        .out_beat  (mid_beat)
    );

    axis_demux demux_i (
        .aclk       (aclk),
        .reset      (reset),
        .in_valid   (mid_valid),
        .in_ready   (mid_ready),
        .in_beat    (mid_beat),
        .out_valid  (route_valid),
        .out_ready  (route_ready),
        .out_beat   (route_beat),
        .drop_count (drop_count)
    );

    generate
        for (genvar k = 0; k < axis_pkg::OUTPUTS; k++) begin : g_tx
            axis_skid_buffer tx_slice_i (
                .aclk      (aclk),
                .reset     (reset),
                .in_valid  (route_valid[k]),
                .in_ready  (route_ready[k]),
                .in_beat   (route_beat[k]),
                .out_valid (tx_tvalid[k]),
                .out_ready (tx_tready[k]),
                .out_beat  (tx_beat[k])
            );

            always_comb tx_tlast[k] = tx_beat[k].tlast;
            always_comb tx_tdata[k] = tx_beat[k].tdata;
            always_comb tx_tstrb[k] = tx_beat[k].tstrb;
            always_comb tx_tkeep[k] = tx_beat[k].tkeep;
            always_comb tx_tdest[k] = tx_beat[k].tdest;
            always_comb tx_tuser[k] = tx_beat[k].tuser;
        end
    endgenerate

endmodule

`default_nettype wire

//--- rtl/axis_pkg.sv
`default_nettype none
// ****************************************
// AXI4-Stream demux shared definitions
// stream sizes, routing field and beat type
// ****************************************

package axis_pkg;

    // data lanes carried on each beat, eight bits per lane.
    localparam int TDATA_BYTES = 4;

    // width of the destination sideband.
    localparam int TDEST_WIDTH = 8;

    // width of the user sideband.
    localparam int TUSER_WIDTH = 4;

    // number of output streams behind the router.
    localparam int OUTPUTS = 6;

    // the routing field is a slice of tdest starting at this bit.
    localparam int DEST_OFFSET = 2;

    // width of the routing field.
    // values at or above OUTPUTS name no stream and the packet is dropped.
    localparam int DEST_BITS = 3;

    // width of the dropped packet counter, which wraps on overflow.
    localparam int DROP_COUNT_WIDTH = 16;

    // one beat of the stream with every sideband carried.
    // tlast sits at the top so a packet boundary is easy to spot in a dump.
    typedef struct packed {
        logic                              tlast;
        logic [TDATA_BYTES-1:0][7:0]       tdata;
        logic [TDATA_BYTES-1:0]            tstrb;
        logic [TDATA_BYTES-1:0]            tkeep;
        logic [TDEST_WIDTH-1:0]            tdest;
        logic [TUSER_WIDTH-1:0]            tuser;
    } axis_beat_t;

endpackage

`default_nettype wire

//--- rtl/axis_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none
// ****************************************
// AXI4-Stream register slice with skid register
// ****************************************

module axis_skid_buffer (
    input  logic                 aclk,
    input  logic                 reset,
    // upstream side
    input  logic                 in_valid,
    output logic                 in_ready,
    input  axis_pkg::axis_beat_t in_beat,
    // downstream side
    output logic                 out_valid,
    input  logic                 out_ready,
    output axis_pkg::axis_beat_t out_beat
);

    logic                 skid_valid;
    axis_pkg::axis_beat_t skid_beat;
    logic                 in_xfer;
    logic                 out_free;

    assign in_xfer  = in_valid && in_ready;

    // the output register can take a new beat when it is empty or being read.
    assign out_free = out_ready || !out_valid;

    // control state.
    // in_ready is a register that mirrors an empty skid, so it is low in reset.
    always_ff @(posedge aclk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else begin
            if (out_free) begin
                if (skid_valid) begin
                    out_valid  <= 1'b1;
                    skid_valid <= 1'b0;
                end else begin
                    out_valid  <= in_xfer;
                end
                in_ready <= 1'b1;
            end else if (in_xfer) begin
                // output is stalled, so the arriving beat parks in the skid.
                skid_valid <= 1'b1;
                in_ready   <= 1'b0;
            end
        end
    end

    // payload registers.
    always_ff @(posedge aclk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_beat <= skid_beat;
            end else if (in_xfer) begin
                out_beat <= in_beat;
            end
        end else if (in_xfer) begin
            skid_beat <= in_beat;
        end
    end

    // a presented beat must be held until the downstream side takes it.
    assert property (@(posedge aclk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else $error("skid buffer changed an unaccepted output beat");

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile the AXI4-Stream demux testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module axis_demux_tb \
    -Mdir obj_dir \
    -o axis_demux_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/axis_demux_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

//--- sim/axis_demux_model.svh
// ****************************************
// AXI4-Stream demux reference routing model
// ****************************************
`ifndef AXIS_DEMUX_MODEL_SVH
`define AXIS_DEMUX_MODEL_SVH

    // beats still owed by each output, oldest first.
    axis_pkg::axis_beat_t exp_q [axis_pkg::OUTPUTS][$];

    // packet state of the model, mirroring the lock and drop rule.
    logic model_in_packet = 1'b0;
    logic model_drop = 1'b0;
    int   model_sel = 0;
    int   model_drops = 0;

    // apply the routing rule to one beat taken on the rx port.
    task automatic model_accept(input axis_pkg::axis_beat_t beat);
        int field;
        field = int'(beat.tdest[axis_pkg::DEST_OFFSET +: axis_pkg::DEST_BITS]);
        // only the first beat of a packet looks at its own tdest.
        if (!model_in_packet) begin
            model_sel  = field;
            model_drop = (field >= axis_pkg::OUTPUTS);
        end
        if (model_drop) begin
            if (beat.tlast) begin
                model_drops++;
            end
        end else begin
            exp_q[model_sel].push_back(beat);
        end
        model_in_packet = !beat.tlast;
    endtask

    // number of beats accepted on rx that have not yet left on tx.
    function automatic int model_pending();
        int total;
        total = 0;
        for (int k = 0; k < axis_pkg::OUTPUTS; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

`endif

//--- sim/axis_demux_tb.sv
`timescale 1ns/10ps
`default_nettype none
// ****************************************
// AXI4-Stream demux testbench
// random packets checked against a routing model
// ****************************************

module axis_demux_tb;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 1;
    localparam int MAX_LEN       = 8;
    localparam int ROUTE_PACKETS = 40;
    localparam int LOCK_PACKETS  = 30;
    localparam int DROP_PACKETS  = 40;
    localparam int BP_PACKETS    = 60;
    localparam int TOTAL_BEATS   =
        (ROUTE_PACKETS + LOCK_PACKETS + DROP_PACKETS + BP_PACKETS) * MAX_LEN;
    localparam int ALL_FIELDS    = 1 << axis_pkg::DEST_BITS;

    logic                                                 aclk;
    logic                                                 reset;
    logic                                                 rx_tvalid;
    logic                                                 rx_tready;
    logic                                                 rx_tlast;
    logic [axis_pkg::TDATA_BYTES-1:0][7:0]                rx_tdata;
    logic [axis_pkg::TDATA_BYTES-1:0]                     rx_tstrb;
    logic [axis_pkg::TDATA_BYTES-1:0]                     rx_tkeep;
    logic [axis_pkg::TDEST_WIDTH-1:0]                     rx_tdest;
    logic [axis_pkg::TUSER_WIDTH-1:0]                     rx_tuser;
    logic [axis_pkg::OUTPUTS-1:0]                         tx_tvalid;
    logic [axis_pkg::OUTPUTS-1:0]                         tx_tready;
    logic [axis_pkg::OUTPUTS-1:0]                         tx_tlast;
    logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0][7:0] tx_tdata;
    logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0] tx_tstrb;
    logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDATA_BYTES-1:0] tx_tkeep;
    logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TDEST_WIDTH-1:0] tx_tdest;
    logic [axis_pkg::OUTPUTS-1:0][axis_pkg::TUSER_WIDTH-1:0] tx_tuser;
    logic [axis_pkg::DROP_COUNT_WIDTH-1:0]                drop_count;

    int   seed = 66;
    int   errors = 0;
    int   tests_run = 0;
    int   tests_failed = 0;
    int   test_start_errors = 0;
    int   test_beats = 0;
    logic throttle = 1'b0;
    logic [axis_pkg::OUTPUTS-1:0] prev_valid;
    logic [axis_pkg::OUTPUTS-1:0] prev_ready;
    axis_pkg::axis_beat_t         prev_beat [axis_pkg::OUTPUTS];

`include "axis_demux_model.svh"

    axis_demux_top dut_i (
        .aclk(aclk), .reset(reset),
        .rx_tvalid(rx_tvalid), .rx_tready(rx_tready), .rx_tlast(rx_tlast),
        .rx_tdata(rx_tdata), .rx_tstrb(rx_tstrb), .rx_tkeep(rx_tkeep),
        .rx_tdest(rx_tdest), .rx_tuser(rx_tuser),
        .tx_tvalid(tx_tvalid), .tx_tready(tx_tready), .tx_tlast(tx_tlast),
        .tx_tdata(tx_tdata), .tx_tstrb(tx_tstrb), .tx_tkeep(tx_tkeep),
        .tx_tdest(tx_tdest), .tx_tuser(tx_tuser),
        .drop_count(drop_count)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // allow 40 cycles for every beat the tests can send.
    initial begin
        #(TOTAL_BEATS * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d ns", TOTAL_BEATS * 40 * CLK_PERIOD);
        $display("Done: errors found");
        $finish;
    end

    // per-output ready, random while throttling and high otherwise.
    initial begin
        tx_tready = '1;
        forever begin
            @(posedge aclk);
            #(DRIVE_DELAY);
            if (throttle) begin
                tx_tready = axis_pkg::OUTPUTS'($random(seed));
            end else begin
                tx_tready = '1;
            end
        end
    end

    function automatic int rand_below(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic axis_pkg::axis_beat_t rx_beat_now();
        axis_pkg::axis_beat_t beat;
        beat.tlast = rx_tlast;
        beat.tdata = rx_tdata;
        beat.tstrb = rx_tstrb;
        beat.tkeep = rx_tkeep;
        beat.tdest = rx_tdest;
        beat.tuser = rx_tuser;
        return beat;
    endfunction

    function automatic axis_pkg::axis_beat_t tx_beat_of(input int k);
        axis_pkg::axis_beat_t beat;
        beat.tlast = tx_tlast[k];
        beat.tdata = tx_tdata[k];
        beat.tstrb = tx_tstrb[k];
        beat.tkeep = tx_tkeep[k];
        beat.tdest = tx_tdest[k];
        beat.tuser = tx_tuser[k];
        return beat;
    endfunction

    // hold rule for a stalled output, then compare any transfer with the model.
    task automatic check_output(input int k);
        axis_pkg::axis_beat_t seen;
        axis_pkg::axis_beat_t expected;
        seen = tx_beat_of(k);
        if (prev_valid[k] && !prev_ready[k]) begin
            if (!tx_tvalid[k]) begin
                $display("[ERROR] %0t: tx %0d dropped tvalid before its transfer", $time, k);
                errors++;
            end else if (seen !== prev_beat[k]) begin
                $display("[ERROR] %0t: tx %0d changed a beat under back-pressure", $time, k);
                errors++;
            end
        end
        if (tx_tvalid[k] && tx_tready[k]) begin
            if (exp_q[k].size() == 0) begin
                $display("output %0d delivered a beat at %0t that no packet sent there",
                         k, $time);
                errors++;
            end else begin
                expected = exp_q[k].pop_front();
                test_beats++;
                if (seen !== expected) begin
                    $display("[ERROR] %0t: tx %0d beat %h, expected %h",
                             $time, k, seen, expected);
                    errors++;
                end
            end
        end
        prev_beat[k] = seen;
    endtask

    // rx acceptance feeds the model before the outputs are checked.
    always @(posedge aclk) begin
        if (reset) begin
            prev_valid = '0;
            prev_ready = '0;
        end else begin
            if (rx_tvalid && rx_tready) begin
                model_accept(rx_beat_now());
            end
            for (int k = 0; k < axis_pkg::OUTPUTS; k++) begin
                check_output(k);
            end
            prev_valid = tx_tvalid;
            prev_ready = tx_tready;
        end
    end

    task automatic drive_beat(input axis_pkg::axis_beat_t beat);
        rx_tvalid = 1'b1;
        rx_tlast  = beat.tlast;
        rx_tdata  = beat.tdata;
        rx_tstrb  = beat.tstrb;
        rx_tkeep  = beat.tkeep;
        rx_tdest  = beat.tdest;
        rx_tuser  = beat.tuser;
        @(posedge aclk);
        while (!rx_tready) begin
            @(posedge aclk);
        end
        #(DRIVE_DELAY);
        rx_tvalid = 1'b0;
    endtask

    // a random packet; later beats may carry a different tdest.
    task automatic send_packet(input int field_limit, input int retarget_pct);
        axis_pkg::axis_beat_t             beat;
        logic [axis_pkg::TDEST_WIDTH-1:0] first_dest;
        int                               len;
        len = 1 + rand_below(MAX_LEN);
        first_dest = axis_pkg::TDEST_WIDTH'($random(seed));
        first_dest[axis_pkg::DEST_OFFSET +: axis_pkg::DEST_BITS] =
            axis_pkg::DEST_BITS'(rand_below(field_limit));
        for (int i = 0; i < len; i++) begin
            beat.tlast = (i == len - 1);
            beat.tdata = $random(seed);
            beat.tstrb = axis_pkg::TDATA_BYTES'($random(seed));
            beat.tkeep = axis_pkg::TDATA_BYTES'($random(seed));
            beat.tuser = axis_pkg::TUSER_WIDTH'($random(seed));
            beat.tdest = first_dest;
            if (i > 0 && rand_below(100) < retarget_pct) begin
                beat.tdest = axis_pkg::TDEST_WIDTH'($random(seed));
            end
            drive_beat(beat);
        end
        repeat (rand_below(3)) begin
            @(posedge aclk);
            #(DRIVE_DELAY);
        end
    endtask

    // wait until every expected beat has left and the drop counts agree.
    task automatic wait_idle();
        int limit;
        int cycles;
        limit = 40 * (model_pending() + MAX_LEN);
        cycles = 0;
        while ((model_pending() != 0 ||
                drop_count != axis_pkg::DROP_COUNT_WIDTH'(model_drops)) && cycles < limit) begin
            @(posedge aclk);
            #(DRIVE_DELAY);
            cycles++;
        end
        if (cycles >= limit) begin
            $display("outputs did not drain: %0d beats still missing after %0d cycles",
                     model_pending(), cycles);
            errors++;
        end
    endtask

    task automatic check_drops();
        if (drop_count !== axis_pkg::DROP_COUNT_WIDTH'(model_drops)) begin
            $display("[ERROR] %0t: drop_count %0d, expected %0d", $time, drop_count, model_drops);
            errors++;
        end
    endtask

    task automatic start_test();
        test_start_errors = errors;
        test_beats = 0;
    endtask

    task automatic end_test(input string name);
        int failed_now;
        failed_now = errors - test_start_errors;
        tests_run++;
        if (failed_now != 0) begin
            tests_failed++;
        end
        $display("test %s: %0d beats checked, %0d errors, %s",
                 name, test_beats, failed_now, (failed_now == 0) ? "pass" : "FAIL");
    endtask

    initial begin
        reset     = 1'b1;
        rx_tvalid = 1'b0;
        rx_tlast  = 1'b0;
        rx_tdata  = '0;
        rx_tstrb  = '0;
        rx_tkeep  = '0;
        rx_tdest  = '0;
        rx_tuser  = '0;
        repeat (3) @(posedge aclk);
        start_test();
        if (rx_tready !== 1'b0) begin
            $display("[ERROR] %0t: rx_tready is high during reset", $time);
            errors++;
        end
        #(DRIVE_DELAY);
        reset = 1'b0;
        if (tx_tvalid !== '0 || drop_count !== '0) begin
            $display("[ERROR] %0t: tx_tvalid %b, drop_count %0d after reset",
                     $time, tx_tvalid, drop_count);
            errors++;
        end
        end_test("reset");

        start_test();
        repeat (ROUTE_PACKETS) send_packet(axis_pkg::OUTPUTS, 0);
        wait_idle();
        end_test("routing");

        start_test();
        repeat (LOCK_PACKETS) send_packet(axis_pkg::OUTPUTS, 60);
        wait_idle();
        end_test("packet_lock");

        start_test();
        repeat (DROP_PACKETS) send_packet(ALL_FIELDS, 30);
        wait_idle();
        check_drops();
        end_test("drops");

        start_test();
        throttle = 1'b1;
        repeat (BP_PACKETS) send_packet(ALL_FIELDS, 30);
        end_test("backpressure");

        // the beats still queued behind back-pressure leave with tready high.
        start_test();
        throttle = 1'b0;
        wait_idle();
        check_drops();
        end_test("drain");

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+sim
rtl/axis_pkg.sv
rtl/axis_skid_buffer.sv
rtl/axis_demux.sv
rtl/axis_demux_top.sv
sim/axis_demux_tb.sv
